//--- design/glb_pkg.sv
// Tile sizes, bank packet structs, APB structs, DMA header and register offsets
package glb_pkg;

    // Word and address widths
    localparam int DATA_WIDTH      = 32;
    localparam int BANKS_PER_TILE  = 2;
    localparam int BANK_ADDR_WIDTH = 8;
    localparam int GLB_ADDR_WIDTH  = 9;
    // Upper word address bits pick the bank
    localparam int BANK_SEL_WIDTH  = GLB_ADDR_WIDTH - BANK_ADDR_WIDTH;
    localparam int APB_ADDR_WIDTH  = 12;

    // Register byte offsets, bit 11 set
    localparam logic [APB_ADDR_WIDTH-1:0] REG_ST_START = 12'h800;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_ST_NUM   = 12'h804;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_LD_START = 12'h808;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_LD_NUM   = 12'h80C;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL     = 12'h810;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS   = 12'h814;

    // Bank write
    typedef struct packed {
        logic                      wr_en;
        logic [GLB_ADDR_WIDTH-1:0] wr_addr;
        logic [DATA_WIDTH-1:0]     wr_data;
    } wr_packet_t;

    // Bank read request
    typedef struct packed {
        logic                      rd_en;
        logic [GLB_ADDR_WIDTH-1:0] rd_addr;
    } rdrq_packet_t;

    // Bank read response
    typedef struct packed {
        logic                  rd_data_valid;
        logic [DATA_WIDTH-1:0] rd_data;
    } rdrs_packet_t;

    // One DMA run, count is one bit wider to hold a full tile
    typedef struct packed {
        logic [GLB_ADDR_WIDTH-1:0] start_addr;
        logic [GLB_ADDR_WIDTH:0]   num_words;
    } dma_header_t;

    // APB master to slave
    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [APB_ADDR_WIDTH-1:0] paddr;
        logic [DATA_WIDTH-1:0]     pwdata;
    } apb_req_t;

    // APB slave to master
    typedef struct packed {
        logic [DATA_WIDTH-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

endpackage

//--- design/glb_bank.sv
// glb_bank: single SRAM bank with one write port and one registered read port
`timescale 1ns/1ps

module glb_bank (
    input  logic                  clk,
    input  logic                  reset,
    input  glb_pkg::wr_packet_t   wr_packet,
    input  glb_pkg::rdrq_packet_t rdrq_packet,
    output glb_pkg::rdrs_packet_t rdrs_packet
);

    // Word storage
    logic [glb_pkg::DATA_WIDTH-1:0]      mem [2**glb_pkg::BANK_ADDR_WIDTH];
    logic [glb_pkg::BANK_ADDR_WIDTH-1:0] wr_addr;
    logic [glb_pkg::BANK_ADDR_WIDTH-1:0] rd_addr;
    logic [glb_pkg::DATA_WIDTH-1:0]      rd_data;
    logic                                rd_valid;

    // Bank already chosen upstream, low bits only
    assign wr_addr = wr_packet.wr_addr[glb_pkg::BANK_ADDR_WIDTH-1:0];
    assign rd_addr = rdrq_packet.rd_addr[glb_pkg::BANK_ADDR_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (wr_packet.wr_en) begin
            mem[wr_addr] <= wr_packet.wr_data;
        end
    end

    // Same-cycle write to same word gives old data here
    always_ff @(posedge clk) begin
        if (rdrq_packet.rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // Response valid one cycle after request
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rdrq_packet.rd_en;
        end
    end

    assign rdrs_packet.rd_data_valid = rd_valid;
    assign rdrs_packet.rd_data       = rd_data;

endmodule

//--- design/glb_switch.sv
// glb_switch: fixed-priority write and read arbitration, bank routing, response steering
`timescale 1ns/1ps

module glb_switch (
    input  logic                  clk,
    input  logic                  reset,

    // Requesters
    input  glb_pkg::wr_packet_t   wr_packet_pr2sw,
    input  glb_pkg::wr_packet_t   wr_packet_d2sw,
    input  glb_pkg::rdrq_packet_t rdrq_packet_pr2sw,
    input  glb_pkg::rdrq_packet_t rdrq_packet_d2sw,
    output glb_pkg::rdrs_packet_t rdrs_packet_sw2pr,
    output glb_pkg::rdrs_packet_t rdrs_packet_sw2d,
    output logic                  proc_wr_grant,
    output logic                  proc_rd_grant,

    // Banks
    output glb_pkg::wr_packet_t   wr_packet_sw2b [glb_pkg::BANKS_PER_TILE],
    output glb_pkg::rdrq_packet_t rdrq_packet_sw2b [glb_pkg::BANKS_PER_TILE],
    input  glb_pkg::rdrs_packet_t rdrs_packet_b2sw_arr [glb_pkg::BANKS_PER_TILE]
);

    glb_pkg::wr_packet_t                wr_sel;
    glb_pkg::rdrq_packet_t              rdrq_sel;
    glb_pkg::rdrs_packet_t              rdrs_sel;
    logic [glb_pkg::BANK_SEL_WIDTH-1:0] wr_bank;
    logic [glb_pkg::BANK_SEL_WIDTH-1:0] rd_bank;
    // Tag of the read in flight
    logic [glb_pkg::BANK_SEL_WIDTH-1:0] tag_bank;
    logic                               tag_dma;

    // DMA always wins, processor only gets idle slots
    assign proc_wr_grant = wr_packet_pr2sw.wr_en & ~wr_packet_d2sw.wr_en;
    assign proc_rd_grant = rdrq_packet_pr2sw.rd_en & ~rdrq_packet_d2sw.rd_en;

    assign wr_sel   = wr_packet_d2sw.wr_en ? wr_packet_d2sw : wr_packet_pr2sw;
    assign rdrq_sel = rdrq_packet_d2sw.rd_en ? rdrq_packet_d2sw : rdrq_packet_pr2sw;

    // Bank from top address bits
    assign wr_bank = wr_sel.wr_addr[glb_pkg::GLB_ADDR_WIDTH-1 -: glb_pkg::BANK_SEL_WIDTH];
    assign rd_bank = rdrq_sel.rd_addr[glb_pkg::GLB_ADDR_WIDTH-1 -: glb_pkg::BANK_SEL_WIDTH];

    // Fan out, enable only the addressed bank
    always_comb begin
        for (int b = 0; b < glb_pkg::BANKS_PER_TILE; b++) begin
            wr_packet_sw2b[b]         = wr_sel;
            wr_packet_sw2b[b].wr_en   = wr_sel.wr_en & (int'(wr_bank) == b);
            rdrq_packet_sw2b[b]       = rdrq_sel;
            rdrq_packet_sw2b[b].rd_en = rdrq_sel.rd_en & (int'(rd_bank) == b);
        end
    end

    // Remember owner and bank for next-cycle response
    always_ff @(posedge clk) begin
        if (reset) begin
            tag_dma  <= 1'b0;
            tag_bank <= '0;
        end else if (rdrq_sel.rd_en) begin
            tag_dma  <= rdrq_packet_d2sw.rd_en;
            tag_bank <= rd_bank;
        end
    end

    assign rdrs_sel = rdrs_packet_b2sw_arr[tag_bank];

    // Steer response to its owner only
    always_comb begin
        rdrs_packet_sw2d                 = rdrs_sel;
        rdrs_packet_sw2d.rd_data_valid   = rdrs_sel.rd_data_valid & tag_dma;
        rdrs_packet_sw2pr                = rdrs_sel;
        rdrs_packet_sw2pr.rd_data_valid  = rdrs_sel.rd_data_valid & ~tag_dma;
    end

endmodule

//--- design/glb_proc_apb.sv
// glb_proc_apb: APB slave for bank memory, DMA header, control and status registers
`timescale 1ns/1ps

module glb_proc_apb (
    input  logic                  clk,
    input  logic                  reset,

    // Processor bus
    input  glb_pkg::apb_req_t     apb_req,
    output glb_pkg::apb_rsp_t     apb_rsp,

    // Switch side
    output glb_pkg::wr_packet_t   wr_packet,
    output glb_pkg::rdrq_packet_t rdrq_packet,
    input  glb_pkg::rdrs_packet_t rdrs_packet,
    input  logic                  wr_grant,
    input  logic                  rd_grant,

    // DMA control
    output glb_pkg::dma_header_t  st_header,
    output glb_pkg::dma_header_t  ld_header,
    output logic                  st_start_pulse,
    output logic                  ld_start_pulse,
    input  logic                  st_done_pulse,
    input  logic                  ld_done_pulse
);

    logic                               access;
    logic                               reg_sel;
    logic                               mem_wr;
    logic                               mem_rd;
    logic                               reg_wr;
    logic                               reg_mapped;
    logic                               rd_pending;
    logic [1:0]                         status;
    logic [1:0]                         status_clr;
    logic [glb_pkg::GLB_ADDR_WIDTH-1:0] word_addr;
    logic [glb_pkg::DATA_WIDTH-1:0]     reg_rdata;

    // Access phase decode, bit 11 picks registers
    assign access  = apb_req.psel & apb_req.penable;
    assign reg_sel = apb_req.paddr[glb_pkg::APB_ADDR_WIDTH-1];
    assign mem_wr  = access & ~reg_sel & apb_req.pwrite;
    assign mem_rd  = access & ~reg_sel & ~apb_req.pwrite;
    assign reg_wr  = access & reg_sel & apb_req.pwrite;

    // Byte to word address
    assign word_addr = apb_req.paddr[glb_pkg::GLB_ADDR_WIDTH+1:2];

    // Write held by APB until granted
    assign wr_packet.wr_en   = mem_wr;
    assign wr_packet.wr_addr = word_addr;
    assign wr_packet.wr_data = apb_req.pwdata;

    // Read request dropped once granted
    assign rdrq_packet.rd_en   = mem_rd & ~rd_pending;
    assign rdrq_packet.rd_addr = word_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pending <= 1'b0;
        end else if (rd_pending & rdrs_packet.rd_data_valid) begin
            rd_pending <= 1'b0;
        end else if (rdrq_packet.rd_en & rd_grant) begin
            rd_pending <= 1'b1;
        end
    end

    // Register read mux
    always_comb begin
        reg_mapped = 1'b1;
        reg_rdata  = '0;
        case (apb_req.paddr)
            glb_pkg::REG_ST_START: reg_rdata[glb_pkg::GLB_ADDR_WIDTH-1:0] = st_header.start_addr;
            glb_pkg::REG_ST_NUM:   reg_rdata[glb_pkg::GLB_ADDR_WIDTH:0]   = st_header.num_words;
            glb_pkg::REG_LD_START: reg_rdata[glb_pkg::GLB_ADDR_WIDTH-1:0] = ld_header.start_addr;
            glb_pkg::REG_LD_NUM:   reg_rdata[glb_pkg::GLB_ADDR_WIDTH:0]   = ld_header.num_words;
            // Start bits are write-only
            glb_pkg::REG_CTRL:     reg_rdata = '0;
            glb_pkg::REG_STATUS:   reg_rdata[1:0] = status;
            default:               reg_mapped = 1'b0;
        endcase
    end

    // Header registers
    always_ff @(posedge clk) begin
        if (reset) begin
            st_header <= '0;
            ld_header <= '0;
        end else if (reg_wr) begin
            case (apb_req.paddr)
                glb_pkg::REG_ST_START:
                    st_header.start_addr <= apb_req.pwdata[glb_pkg::GLB_ADDR_WIDTH-1:0];
                glb_pkg::REG_ST_NUM:
                    st_header.num_words <= apb_req.pwdata[glb_pkg::GLB_ADDR_WIDTH:0];
                glb_pkg::REG_LD_START:
                    ld_header.start_addr <= apb_req.pwdata[glb_pkg::GLB_ADDR_WIDTH-1:0];
                glb_pkg::REG_LD_NUM:
                    ld_header.num_words <= apb_req.pwdata[glb_pkg::GLB_ADDR_WIDTH:0];
                default: ;
            endcase
        end
    end

    // Register access lasts one cycle, so these are single pulses
    assign st_start_pulse = reg_wr & (apb_req.paddr == glb_pkg::REG_CTRL) & apb_req.pwdata[0];
    assign ld_start_pulse = reg_wr & (apb_req.paddr == glb_pkg::REG_CTRL) & apb_req.pwdata[1];

    // Sticky done bits, write 1 to clear, new done wins
    assign status_clr = (reg_wr & (apb_req.paddr == glb_pkg::REG_STATUS)) ?
                        apb_req.pwdata[1:0] : 2'b00;

    always_ff @(posedge clk) begin
        if (reset) begin
            status <= 2'b00;
        end else begin
            status <= (status & ~status_clr) | {ld_done_pulse, st_done_pulse};
        end
    end

    // Response
    always_comb begin
        apb_rsp.prdata  = reg_sel ? reg_rdata : rdrs_packet.rd_data;
        apb_rsp.pready  = (access & reg_sel) | (mem_wr & wr_grant)
                        | (mem_rd & rd_pending & rdrs_packet.rd_data_valid);
        apb_rsp.pslverr = access & reg_sel & ~reg_mapped;
    end

endmodule

//--- design/glb_store_dma.sv
// glb_store_dma: stream words to sequential bank writes with done pulse
`timescale 1ns/1ps

module glb_store_dma (
    input  logic                           clk,
    input  logic                           reset,
    input  glb_pkg::dma_header_t           header,
    input  logic                           start_pulse,
    input  logic [glb_pkg::DATA_WIDTH-1:0] stream_data_f2g,
    input  logic                           stream_data_valid_f2g,
    output glb_pkg::wr_packet_t            wr_packet,
    output logic                           done_pulse
);

    logic                               active;
    logic [glb_pkg::GLB_ADDR_WIDTH-1:0] addr;
    logic [glb_pkg::GLB_ADDR_WIDTH:0]   remaining;
    logic                               done;
    logic                               wr_fire;

    // Word written in the cycle it arrives
    assign wr_fire = active & stream_data_valid_f2g;

    assign wr_packet.wr_en   = wr_fire;
    assign wr_packet.wr_addr = addr;
    assign wr_packet.wr_data = stream_data_f2g;

    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            addr      <= '0;
            remaining <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start_pulse) begin
                // Zero-length run never goes active
                active    <= (header.num_words != '0);
                addr      <= header.start_addr;
                remaining <= header.num_words;
            end else if (wr_fire) begin
                addr      <= addr + 1'b1;
                remaining <= remaining - 1'b1;
                // Last word
                if (remaining == 1) begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    // One cycle after the last write
    assign done_pulse = done;

endmodule

//--- design/glb_load_dma.sv
// glb_load_dma: sequential bank reads forwarded as a registered stream with done pulse
`timescale 1ns/1ps

module glb_load_dma (
    input  logic                           clk,
    input  logic                           reset,
    input  glb_pkg::dma_header_t           header,
    input  logic                           start_pulse,
    output glb_pkg::rdrq_packet_t          rdrq_packet,
    input  glb_pkg::rdrs_packet_t          rdrs_packet,
    output logic [glb_pkg::DATA_WIDTH-1:0] stream_data_g2f,
    output logic                           stream_data_valid_g2f,
    output logic                           done_pulse
);

    // Request side
    logic                               rq_active;
    logic [glb_pkg::GLB_ADDR_WIDTH-1:0] rq_addr;
    logic [glb_pkg::GLB_ADDR_WIDTH:0]   rq_remaining;
    // Response side
    logic [glb_pkg::GLB_ADDR_WIDTH:0]   rs_remaining;
    logic [glb_pkg::DATA_WIDTH-1:0]     data_q;
    logic                               valid_q;
    logic                               done_q;

    assign rdrq_packet.rd_en   = rq_active;
    assign rdrq_packet.rd_addr = rq_addr;

    // One read per cycle, never stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            rq_active    <= 1'b0;
            rq_addr      <= '0;
            rq_remaining <= '0;
        end else if (start_pulse) begin
            rq_active    <= (header.num_words != '0);
            rq_addr      <= header.start_addr;
            rq_remaining <= header.num_words;
        end else if (rq_active) begin
            rq_addr      <= rq_addr + 1'b1;
            rq_remaining <= rq_remaining - 1'b1;
            if (rq_remaining == 1) begin
                rq_active <= 1'b0;
            end
        end
    end

    // Count returning words, done rides with the last one
    always_ff @(posedge clk) begin
        if (reset) begin
            rs_remaining <= '0;
            valid_q      <= 1'b0;
            done_q       <= 1'b0;
        end else begin
            valid_q <= rdrs_packet.rd_data_valid;
            done_q  <= rdrs_packet.rd_data_valid & (rs_remaining == 1);
            if (start_pulse) begin
                rs_remaining <= header.num_words;
            end else if (rdrs_packet.rd_data_valid) begin
                rs_remaining <= rs_remaining - 1'b1;
            end
        end
    end

    // Registered stream word
    always_ff @(posedge clk) begin
        if (rdrs_packet.rd_data_valid) begin
            data_q <= rdrs_packet.rd_data;
        end
    end

    assign stream_data_g2f       = data_q;
    assign stream_data_valid_g2f = valid_q;
    assign done_pulse            = done_q;

endmodule

//--- design/glb_tile.sv
// glb_tile: banks, packet switch, APB slave, store and load DMA
`timescale 1ns/1ps

module glb_tile (
    input  logic                           clk,
    input  logic                           reset,

    // Processor
    input  glb_pkg::apb_req_t              apb_req,
    output glb_pkg::apb_rsp_t              apb_rsp,

    // Fabric streams
    input  logic [glb_pkg::DATA_WIDTH-1:0] stream_data_f2g,
    input  logic                           stream_data_valid_f2g,
    output logic [glb_pkg::DATA_WIDTH-1:0] stream_data_g2f,
    output logic                           stream_data_valid_g2f,

    // Bit 0 store done, bit 1 load done
    output logic [1:0]                     interrupt_pulse
);

    glb_pkg::wr_packet_t   wr_packet_pr2sw;
    glb_pkg::wr_packet_t   wr_packet_d2sw;
    glb_pkg::rdrq_packet_t rdrq_packet_pr2sw;
    glb_pkg::rdrq_packet_t rdrq_packet_d2sw;
    glb_pkg::rdrs_packet_t rdrs_packet_sw2pr;
    glb_pkg::rdrs_packet_t rdrs_packet_sw2d;
    logic                  proc_wr_grant;
    logic                  proc_rd_grant;
    glb_pkg::wr_packet_t   wr_packet_sw2b [glb_pkg::BANKS_PER_TILE];
    glb_pkg::rdrq_packet_t rdrq_packet_sw2b [glb_pkg::BANKS_PER_TILE];
    glb_pkg::rdrs_packet_t rdrs_packet_b2sw_arr [glb_pkg::BANKS_PER_TILE];
    glb_pkg::dma_header_t  st_header;
    glb_pkg::dma_header_t  ld_header;
    logic                  st_start_pulse;
    logic                  ld_start_pulse;
    logic                  st_done_pulse;
    logic                  ld_done_pulse;

    // Banks
    for (genvar i = 0; i < glb_pkg::BANKS_PER_TILE; i++) begin : g_bank
        glb_bank bank (
            .wr_packet   (wr_packet_sw2b[i]),
            .rdrq_packet (rdrq_packet_sw2b[i]),
            .rdrs_packet (rdrs_packet_b2sw_arr[i]),
            .*);
    end

    // All switch port names match
    glb_switch glb_switch (.*);

    glb_proc_apb proc_apb (
        .wr_packet   (wr_packet_pr2sw),
        .rdrq_packet (rdrq_packet_pr2sw),
        .rdrs_packet (rdrs_packet_sw2pr),
        .wr_grant    (proc_wr_grant),
        .rd_grant    (proc_rd_grant),
        .*);

    glb_store_dma store_dma (
        .header      (st_header),
        .start_pulse (st_start_pulse),
        .wr_packet   (wr_packet_d2sw),
        .done_pulse  (st_done_pulse),
        .*);

    glb_load_dma load_dma (
        .header      (ld_header),
        .start_pulse (ld_start_pulse),
        .rdrq_packet (rdrq_packet_d2sw),
        .rdrs_packet (rdrs_packet_sw2d),
        .done_pulse  (ld_done_pulse),
        .*);

    assign interrupt_pulse = {ld_done_pulse, st_done_pulse};

endmodule

//--- sim/glb_tile_assertions.sv
// glb_tile_assertions: switch checks for single-bank writes, read latency and DMA priority, plus bind
`timescale 1ns/1ps

module glb_tile_assertions (
    input logic                  clk,
    input logic                  reset,
    input glb_pkg::wr_packet_t   wr_packet_d2sw,
    input glb_pkg::rdrq_packet_t rdrq_packet_d2sw,
    input logic                  proc_wr_grant,
    input logic                  proc_rd_grant,
    input glb_pkg::wr_packet_t   wr_packet_sw2b [glb_pkg::BANKS_PER_TILE],
    input glb_pkg::rdrq_packet_t rdrq_packet_sw2b [glb_pkg::BANKS_PER_TILE],
    input glb_pkg::rdrs_packet_t rdrs_packet_b2sw_arr [glb_pkg::BANKS_PER_TILE]
);

    // Failures seen so far
    int fail_count = 0;
    logic [glb_pkg::BANKS_PER_TILE-1:0] bank_wr_en;

    always_comb begin
        for (int b = 0; b < glb_pkg::BANKS_PER_TILE; b++) begin
            bank_wr_en[b] = wr_packet_sw2b[b].wr_en;
        end
    end

    // One write port per tile
    one_bank_write: assert property (@(posedge clk) disable iff (reset)
        $onehot0(bank_wr_en))
    else begin
        fail_count++;
        $error("more than one bank written in one cycle");
    end

    // Every bank answers exactly one cycle later
    for (genvar b = 0; b < glb_pkg::BANKS_PER_TILE; b++) begin : g_rd
        rd_latency: assert property (@(posedge clk) disable iff (reset)
            rdrq_packet_sw2b[b].rd_en |=> rdrs_packet_b2sw_arr[b].rd_data_valid)
        else begin
            fail_count++;
            $error("bank %0d read response missing", b);
        end
    end

    // DMA owns its channel whenever it asks
    wr_dma_priority: assert property (@(posedge clk) disable iff (reset)
        wr_packet_d2sw.wr_en |-> !proc_wr_grant)
    else begin
        fail_count++;
        $error("processor write granted over store DMA");
    end

    rd_dma_priority: assert property (@(posedge clk) disable iff (reset)
        rdrq_packet_d2sw.rd_en |-> !proc_rd_grant)
    else begin
        fail_count++;
        $error("processor read granted over load DMA");
    end

endmodule

bind glb_switch glb_tile_assertions switch_checks (.*);

//--- sim/glb_tile_tb.sv
// Testbench top with clock, reset, APB and stream drivers, monitor, compare tasks and five tests
`timescale 1ns/1ps

module glb_tile_tb;

    localparam int CLK_PERIOD = 10;
    // Rough cycle cost of each test in run order
    localparam int TEST_CYCLES = 100 + 100 + 200 + 250 + 400;
    localparam int MARGIN_CYCLES = 1000;
    localparam int PULSE_WAIT_CYCLES = 300;

    logic                           clk;
    logic                           reset;
    glb_pkg::apb_req_t              apb_req;
    glb_pkg::apb_rsp_t              apb_rsp;
    logic [glb_pkg::DATA_WIDTH-1:0] stream_data_f2g;
    logic                           stream_data_valid_f2g;
    logic [glb_pkg::DATA_WIDTH-1:0] stream_data_g2f;
    logic                           stream_data_valid_g2f;
    logic [1:0]                     interrupt_pulse;

    // Expected bank contents by tile word address
    logic [glb_pkg::DATA_WIDTH-1:0] model_mem [2**glb_pkg::GLB_ADDR_WIDTH];
    logic [glb_pkg::DATA_WIDTH-1:0] rx_q [$];
    int                             pulse_cnt [2];
    logic [31:0]                    rng_state = 32'h981d;

    glb_tile dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Output stream and interrupt monitor
    always @(posedge clk) begin
        if (!reset) begin
            if (stream_data_valid_g2f) begin
                rx_q.push_back(stream_data_g2f);
            end
            if (interrupt_pulse[0]) begin
                pulse_cnt[0]++;
            end
            if (interrupt_pulse[1]) begin
                pulse_cnt[1]++;
            end
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input logic [glb_pkg::DATA_WIDTH-1:0] got,
                              input logic [glb_pkg::DATA_WIDTH-1:0] exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_rsp(input glb_pkg::apb_rsp_t rsp, input logic exp_err,
                             input string what);
        if (rsp.pslverr !== exp_err) begin
            stop_run($sformatf("CHECK FAILED at %0t: %s pslverr %b expected %b",
                               $time, what, rsp.pslverr, exp_err));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            stop_run($sformatf("CHECK FAILED at %0t: %s count %0d expected %0d",
                               $time, what, got, exp));
        end
    endtask

    // Setup phase then access phase held until pready
    task automatic apb_xfer(input logic wr, input logic [glb_pkg::APB_ADDR_WIDTH-1:0] addr,
                            input logic [glb_pkg::DATA_WIDTH-1:0] wdata,
                            output glb_pkg::apb_rsp_t rsp);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(posedge clk);
        while (!apb_rsp.pready) begin
            @(posedge clk);
        end
        rsp = apb_rsp;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [glb_pkg::APB_ADDR_WIDTH-1:0] addr,
                             input logic [glb_pkg::DATA_WIDTH-1:0] data);
        glb_pkg::apb_rsp_t rsp;
        apb_xfer(1'b1, addr, data, rsp);
        check_rsp(rsp, 1'b0, $sformatf("write %h", addr));
    endtask

    task automatic apb_read(input logic [glb_pkg::APB_ADDR_WIDTH-1:0] addr,
                            output logic [glb_pkg::DATA_WIDTH-1:0] data);
        glb_pkg::apb_rsp_t rsp;
        apb_xfer(1'b0, addr, '0, rsp);
        check_rsp(rsp, 1'b0, $sformatf("read %h", addr));
        data = rsp.prdata;
    endtask

    // Byte address is word address times 4 with bit 11 low
    task automatic mem_write(input logic [glb_pkg::GLB_ADDR_WIDTH-1:0] w,
                             input logic [glb_pkg::DATA_WIDTH-1:0] data);
        model_mem[w] = data;
        apb_write({1'b0, w, 2'b00}, data);
    endtask

    task automatic mem_check(input logic [glb_pkg::GLB_ADDR_WIDTH-1:0] w);
        logic [glb_pkg::DATA_WIDTH-1:0] data;
        apb_read({1'b0, w, 2'b00}, data);
        check_word(data, model_mem[w], $sformatf("memory word %0d", w));
    endtask

    task automatic mem_check_range(input logic [glb_pkg::GLB_ADDR_WIDTH-1:0] start,
                                   input int n);
        for (int i = 0; i < n; i++) begin
            mem_check(start + (glb_pkg::GLB_ADDR_WIDTH)'(i));
        end
    endtask

    task automatic status_check(input logic [glb_pkg::DATA_WIDTH-1:0] exp, input string what);
        logic [glb_pkg::DATA_WIDTH-1:0] data;
        apb_read(glb_pkg::REG_STATUS, data);
        check_word(data, exp, what);
    endtask

    task automatic start_dma(input logic is_load, input logic [glb_pkg::GLB_ADDR_WIDTH-1:0] start,
                             input int n);
        apb_write(is_load ? glb_pkg::REG_LD_START : glb_pkg::REG_ST_START, start);
        apb_write(is_load ? glb_pkg::REG_LD_NUM : glb_pkg::REG_ST_NUM, n);
        apb_write(glb_pkg::REG_CTRL, is_load ? 32'h2 : 32'h1);
    endtask

    // Every third word is followed by an idle cycle
    task automatic stream_in(input logic [glb_pkg::GLB_ADDR_WIDTH-1:0] start, input int n);
        logic [glb_pkg::DATA_WIDTH-1:0] w;
        for (int i = 0; i < n; i++) begin
            w = next_rand();
            model_mem[start + (glb_pkg::GLB_ADDR_WIDTH)'(i)] = w;
            @(negedge clk);
            stream_data_f2g       = w;
            stream_data_valid_f2g = 1'b1;
            if (i % 3 == 2) begin
                @(negedge clk);
                stream_data_valid_f2g = 1'b0;
            end
        end
        @(negedge clk);
        stream_data_valid_f2g = 1'b0;
    endtask

    task automatic clear_monitor();
        @(negedge clk);
        rx_q.delete();
        pulse_cnt[0] = 0;
        pulse_cnt[1] = 0;
    endtask

    // Bounded wait for the pulse and a few cycles more to catch extra pulses
    task automatic wait_pulse(input int idx);
        int cycles;
        cycles = 0;
        while (pulse_cnt[idx] == 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > PULSE_WAIT_CYCLES) begin
                stop_run($sformatf("No done interrupt on bit %0d within %0d cycles",
                                   idx, PULSE_WAIT_CYCLES));
            end
        end
        repeat (4) @(negedge clk);
        check_count(pulse_cnt[idx], 1, $sformatf("interrupt bit %0d pulses", idx));
    endtask

    task automatic stream_check(input logic [glb_pkg::GLB_ADDR_WIDTH-1:0] start, input int n);
        check_count(rx_q.size(), n, "g2f words");
        for (int i = 0; i < n; i++) begin
            check_word(rx_q[i], model_mem[start + (glb_pkg::GLB_ADDR_WIDTH)'(i)],
                       $sformatf("g2f word %0d", i));
        end
    endtask

    // Words 255 and 511 share low bits across the two banks
    task automatic mem_readback();
        logic [glb_pkg::GLB_ADDR_WIDTH-1:0] words [6];
        words = '{9'd3, 9'd10, 9'd255, 9'd256, 9'd300, 9'd511};
        foreach (words[i]) begin
            mem_write(words[i], next_rand());
        end
        foreach (words[i]) begin
            mem_check(words[i]);
        end
    endtask

    task automatic register_access();
        logic [glb_pkg::DATA_WIDTH-1:0] data;
        glb_pkg::apb_rsp_t              rsp;
        // No DMA has run yet
        status_check(32'h0, "status after reset");
        apb_write(glb_pkg::REG_ST_START, 32'h0A5);
        apb_write(glb_pkg::REG_ST_NUM, 32'h200);
        apb_write(glb_pkg::REG_LD_START, 32'h1C3);
        apb_write(glb_pkg::REG_LD_NUM, 32'h007);
        apb_read(glb_pkg::REG_ST_START, data);
        check_word(data, 32'h0A5, "store start register");
        apb_read(glb_pkg::REG_ST_NUM, data);
        check_word(data, 32'h200, "store count register");
        apb_read(glb_pkg::REG_LD_START, data);
        check_word(data, 32'h1C3, "load start register");
        apb_read(glb_pkg::REG_LD_NUM, data);
        check_word(data, 32'h007, "load count register");
        // Control reads as zero
        apb_read(glb_pkg::REG_CTRL, data);
        check_word(data, 32'h0, "control register");
        apb_xfer(1'b0, 12'h818, '0, rsp);
        check_rsp(rsp, 1'b1, "unmapped register read");
        apb_xfer(1'b1, 12'hFFC, 32'h1, rsp);
        check_rsp(rsp, 1'b1, "unmapped register write");
    endtask

    // Region crosses from bank 0 into bank 1
    task automatic store_dma_run();
        clear_monitor();
        start_dma(1'b0, 9'd250, 12);
        stream_in(9'd250, 12);
        wait_pulse(0);
        status_check(32'h1, "status after store");
        mem_check_range(9'd250, 12);
        apb_write(glb_pkg::REG_STATUS, 32'h1);
        status_check(32'h0, "status after store clear");
    endtask

    task automatic load_dma_run();
        for (int i = 0; i < 16; i++) begin
            mem_write(9'd248 + 9'(i), next_rand());
        end
        clear_monitor();
        start_dma(1'b1, 9'd248, 16);
        wait_pulse(1);
        stream_check(9'd248, 16);
        status_check(32'h2, "status after load");
        apb_write(glb_pkg::REG_STATUS, 32'h2);
    endtask

    task automatic dma_contention();
        logic [glb_pkg::DATA_WIDTH-1:0] wdata_a;
        logic [glb_pkg::DATA_WIDTH-1:0] wdata_b;
        for (int i = 0; i < 24; i++) begin
            mem_write(9'h040 + 9'(i), next_rand());
        end
        wdata_a = next_rand();
        wdata_b = next_rand();
        // Write goes in beside the load reads, then reads stall behind the DMA
        clear_monitor();
        start_dma(1'b1, 9'h040, 24);
        mem_write(9'd11, wdata_a);
        mem_check(9'd10);
        mem_check(9'd11);
        mem_check(9'h045);
        wait_pulse(1);
        stream_check(9'h040, 24);
        // Processor writes slip into stream gaps
        start_dma(1'b0, 9'h180, 16);
        fork
            stream_in(9'h180, 16);
            begin
                mem_write(9'h1F0, wdata_b);
                mem_check(9'h1F0);
                mem_check(9'd3);
            end
        join
        wait_pulse(0);
        mem_check_range(9'h180, 16);
        status_check(32'h3, "status after both DMAs");
        apb_write(glb_pkg::REG_STATUS, 32'h3);
        status_check(32'h0, "status after final clear");
    endtask

    // Watchdog
    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        stop_run("Timeout: the tests did not finish in the expected time");
    end

    // First switch assertion failure ends the run
    initial begin
        wait (dut_i.glb_switch.switch_checks.fail_count != 0);
        stop_run("A switch assertion failed during the run");
    end

    initial begin
        clk                   = 1'b0;
        reset                 = 1'b1;
        apb_req               = '0;
        stream_data_f2g       = '0;
        stream_data_valid_f2g = 1'b0;
        pulse_cnt[0]          = 0;
        pulse_cnt[1]          = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_count(int'({apb_rsp.pready, stream_data_valid_g2f, interrupt_pulse}), 0,
                    "active outputs after reset");
        mem_readback();
        register_access();
        store_dma_run();
        load_dma_run();
        dma_contention();
        repeat (2) @(negedge clk);
        if (dut_i.glb_switch.switch_checks.fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            stop_run("Switch assertions failed during the run");
        end
    end

endmodule

//--- build.f
design/glb_pkg.sv
design/glb_bank.sv
design/glb_switch.sv
design/glb_proc_apb.sv
design/glb_store_dma.sv
design/glb_load_dma.sv
design/glb_tile.sv
sim/glb_tile_assertions.sv
sim/glb_tile_tb.sv
